// File: include/channel_sum_config.svh
`ifndef CHANNEL_SUM_CONFIG_SVH
`define CHANNEL_SUM_CONFIG_SVH

////////////////////
// Group geometry
////////////////////

// Channel planes per group, a power of two and at least 2
`define CS_CHANNELS 8

// Pixels in one channel plane
`define CS_PLANE_SIZE 16

////////////////////
// Data widths
////////////////////

// Signed input pixel
`define CS_PIXEL_W 16

`endif

// File: design/channel_sum_pkg.sv
`default_nettype none

`include "channel_sum_config.svh"

package channel_sum_pkg;

  ////////////////////
  // Derived sizes
  ////////////////////

  // One adder level per halving of the channel group
  localparam int cs_levels = $clog2(`CS_CHANNELS);

  localparam int cs_pos_w  = (`CS_PLANE_SIZE > 1) ? $clog2(`CS_PLANE_SIZE) : 1;
  localparam int cs_chan_w = $clog2(`CS_CHANNELS);

  ////////////////////
  // Types
  ////////////////////

  typedef logic signed [`CS_PIXEL_W-1:0] pixel_t;

  // One extra bit per tree level, so a full group sum never wraps
  typedef logic signed [`CS_PIXEL_W+cs_levels-1:0] sum_t;

  // Pixel index within a plane
  typedef logic [cs_pos_w-1:0] pos_t;

  // Channel index within a group
  typedef logic [cs_chan_w-1:0] chan_t;

endpackage

`default_nettype wire

// File: design/plane_delay.sv
`timescale 1ns/1ns
`default_nettype none

`include "channel_sum_config.svh"

module plane_delay #(
  parameter int DEPTH = `CS_PLANE_SIZE
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    valid_in,
  input  channel_sum_pkg::pixel_t data_in,
  output channel_sum_pkg::pixel_t data_out
);

  import channel_sum_pkg::*;

  // Entry 0 holds the newest pixel, entry DEPTH-1 the oldest
  pixel_t line_q [DEPTH];

  ////////////////////
  // Shift on valid
  ////////////////////

  // Gaps in the stream leave the line untouched
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        line_q[i] <= '0;
      end
    end else if (valid_in) begin
      line_q[0] <= data_in;
      for (int i = 1; i < DEPTH; i++) begin
        line_q[i] <= line_q[i-1];
      end
    end
  end

  // Pixel seen DEPTH valid strobes ago
  assign data_out = line_q[DEPTH-1];

endmodule

`default_nettype wire

// File: design/channel_window.sv
`timescale 1ns/1ns
`default_nettype none

`include "channel_sum_config.svh"

module channel_window (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    pixel_valid,
  input  channel_sum_pkg::pixel_t pixel_in,
  output channel_sum_pkg::pixel_t taps [`CS_CHANNELS],
  output logic                    taps_valid
);

  import channel_sum_pkg::*;

  localparam pos_t  last_pos  = pos_t'(`CS_PLANE_SIZE - 1);
  localparam chan_t last_chan = chan_t'(`CS_CHANNELS - 1);

  ////////////////////
  // Plane delay chain
  ////////////////////

  // chain[j] lags the live pixel by j planes, so it carries channel
  // CS_CHANNELS-1-j while the last channel streams in
  pixel_t chain [`CS_CHANNELS];

  assign chain[0] = pixel_in;

  for (genvar j = 0; j < `CS_CHANNELS - 1; j++) begin : delay_g
    plane_delay #(
      .DEPTH(`CS_PLANE_SIZE)
    ) plane_delay_i (
      .clk     (clk),
      .reset   (reset),
      .valid_in(pixel_valid),
      .data_in (chain[j]),
      .data_out(chain[j+1])
    );
  end

  ////////////////////
  // Group position
  ////////////////////

  pos_t  pos_q;
  chan_t chan_q;
  logic  pos_wrap;
  logic  last_chan_pixel;

  assign pos_wrap        = (pos_q == last_pos);
  assign last_chan_pixel = pixel_valid && (chan_q == last_chan);

  // Runs across group boundaries without a restart
  always_ff @(posedge clk) begin
    if (reset) begin
      pos_q  <= '0;
      chan_q <= '0;
    end else if (pixel_valid) begin
      if (pos_wrap) begin
        pos_q  <= '0;
        chan_q <= (chan_q == last_chan) ? '0 : chan_q + 1'b1;
      end else begin
        pos_q <= pos_q + 1'b1;
      end
    end
  end

  ////////////////////
  // Tap registers
  ////////////////////

  // Reorder so that tap k is channel k
  always_ff @(posedge clk) begin
    if (last_chan_pixel) begin
      for (int k = 0; k < `CS_CHANNELS; k++) begin
        taps[k] <= chain[`CS_CHANNELS-1-k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      taps_valid <= 1'b0;
    end else begin
      taps_valid <= last_chan_pixel;
    end
  end

endmodule

`default_nettype wire

// File: design/adder_tree.sv
`timescale 1ns/1ns
`default_nettype none

`include "channel_sum_config.svh"

module adder_tree (
  input  logic                    clk,
  input  logic                    reset,
  input  channel_sum_pkg::pixel_t taps [`CS_CHANNELS],
  input  logic                    taps_valid,
  output channel_sum_pkg::sum_t   sum_out,
  output logic                    sum_valid
);

  import channel_sum_pkg::*;

  // node[l][k] is operand k entering level l, held at full sum width
  sum_t               node [cs_levels+1][`CS_CHANNELS];
  logic [cs_levels:0] stage_valid;

  assign stage_valid[0] = taps_valid;

  for (genvar k = 0; k < `CS_CHANNELS; k++) begin : leaf_g
    assign node[0][k] = sum_t'(taps[k]);
  end

  ////////////////////
  // Tree levels
  ////////////////////

  for (genvar l = 0; l < cs_levels; l++) begin : level_g
    localparam int in_w  = `CS_PIXEL_W + l;
    localparam int out_w = in_w + 1;
    localparam int nodes = `CS_CHANNELS >> (l + 1);

    logic valid_q;

    always_ff @(posedge clk) begin
      if (reset) begin
        valid_q <= 1'b0;
      end else begin
        valid_q <= stage_valid[l];
      end
    end

    assign stage_valid[l+1] = valid_q;

    // Pair 2i and 2i+1, one bit wider than the operands
    for (genvar i = 0; i < nodes; i++) begin : pair_g
      logic signed [in_w-1:0]  op_a;
      logic signed [in_w-1:0]  op_b;
      logic signed [out_w-1:0] pair_q;

      assign op_a = node[l][2*i][in_w-1:0];
      assign op_b = node[l][2*i+1][in_w-1:0];

      always_ff @(posedge clk) begin
        if (stage_valid[l]) begin
          pair_q <= {op_a[in_w-1], op_a} + {op_b[in_w-1], op_b};
        end
      end

      assign node[l+1][i] = sum_t'(pair_q);
    end

    // Slots past the last pair of this level
    for (genvar i = nodes; i < `CS_CHANNELS; i++) begin : idle_g
      assign node[l+1][i] = '0;
    end
  end

  ////////////////////
  // Result
  ////////////////////

  assign sum_out   = node[cs_levels][0];
  assign sum_valid = stage_valid[cs_levels];

endmodule

`default_nettype wire

// File: design/channel_sum_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "channel_sum_config.svh"

module channel_sum_top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    pixel_valid,
  input  channel_sum_pkg::pixel_t pixel_in,
  output logic                    sum_valid,
  output channel_sum_pkg::sum_t   sum_out
);

  import channel_sum_pkg::*;

  // Aligned channel pixels for one position
  pixel_t taps [`CS_CHANNELS];
  logic   taps_valid;

  ////////////////////
  // Alignment
  ////////////////////

  channel_window channel_window_i (
    .clk        (clk),
    .reset      (reset),
    .pixel_valid(pixel_valid),
    .pixel_in   (pixel_in),
    .taps       (taps),
    .taps_valid (taps_valid)
  );

  ////////////////////
  // Summation
  ////////////////////

  // cs_levels cycles behind taps_valid
  adder_tree adder_tree_i (
    .clk       (clk),
    .reset     (reset),
    .taps      (taps),
    .taps_valid(taps_valid),
    .sum_out   (sum_out),
    .sum_valid (sum_valid)
  );

endmodule

`default_nettype wire

// File: tb/channel_sum_sva.sv
`timescale 1ns/1ns
`default_nettype none

module channel_sum_sva (
  input logic                                   clk,
  input logic                                   reset,
  input logic                                   pixel_valid,
  input logic                                   last_chan_pixel,
  input logic                                   taps_valid,
  input logic [channel_sum_pkg::cs_levels:0]    stage_valid,
  input logic                                   sum_valid
);

  import channel_sum_pkg::*;

  // Bit k set when a last-channel pixel was sampled k+1 edges back
  logic [cs_levels:0] last_hist;

  always_ff @(posedge clk) begin
    if (reset) begin
      last_hist <= '0;
    end else begin
      last_hist <= {last_hist[cs_levels-1:0], last_chan_pixel};
    end
  end

  ////////////////////
  // Properties
  ////////////////////

  sum_latency_a: assert property (
    @(posedge clk) disable iff (reset) sum_valid == last_hist[cs_levels]
  ) else $error("sum_valid not %0d cycles after a last-channel pixel", cs_levels + 1);

  taps_source_a: assert property (
    @(posedge clk) disable iff (reset) $rose(taps_valid) |-> $past(pixel_valid)
  ) else $error("taps_valid rose without a valid pixel before it");

  // All pipeline valid bits clear right after reset
  reset_clear_a: assert property (
    @(posedge clk) reset |=> (stage_valid == '0) && !taps_valid && !sum_valid
  ) else $error("valid bit high in the cycle after reset");

endmodule

bind channel_sum_top channel_sum_sva channel_sum_sva_i (
  .clk            (clk),
  .reset          (reset),
  .pixel_valid    (pixel_valid),
  .last_chan_pixel(channel_window_i.last_chan_pixel),
  .taps_valid     (taps_valid),
  .stage_valid    (adder_tree_i.stage_valid),
  .sum_valid      (sum_valid)
);

`default_nettype wire

// File: tb/channel_sum_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "channel_sum_config.svh"

module channel_sum_tb;

  import channel_sum_pkg::*;

  localparam int channels    = `CS_CHANNELS;
  localparam int plane_size  = `CS_PLANE_SIZE;
  localparam int latency     = 1 + cs_levels;
  localparam int drain_limit = 200;

  localparam int mode_random = 0;
  localparam int mode_max    = 1;
  localparam int mode_min    = 2;

  localparam pixel_t pix_max = {1'b0, {(`CS_PIXEL_W-1){1'b1}}};
  localparam pixel_t pix_min = {1'b1, {(`CS_PIXEL_W-1){1'b0}}};

  logic   clk;
  logic   reset;
  logic   pixel_valid;
  pixel_t pixel_in;
  logic   sum_valid;
  sum_t   sum_out;

  int cycle_count;
  int mismatch_errors;
  int latency_errors;
  int protocol_errors;
  int sums_expected;
  int sums_received;
  int full_groups;

  // Reference model state
  pos_t   m_pos;
  chan_t  m_chan;
  pixel_t plane_mem [channels][plane_size];
  sum_t   exp_sum_q [$];
  int     exp_edge_q [$];

  channel_sum_top channel_sum_top_i (
    .clk        (clk),
    .reset      (reset),
    .pixel_valid(pixel_valid),
    .pixel_in   (pixel_in),
    .sum_valid  (sum_valid),
    .sum_out    (sum_out)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic compare_sum(input sum_t expected, input sum_t actual);
    if (actual !== expected) begin
      mismatch_errors++;
      $display("MISMATCH sum_out expected 0x%h actual 0x%h", expected, actual);
    end
  endtask

  task automatic compare_latency(input int expected, input int actual);
    if (actual != expected) begin
      latency_errors++;
      $display("MISMATCH latency expected 0x%h actual 0x%h", expected, actual);
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  // Records one accepted pixel and queues the sum once the last channel arrives
  task automatic model_accept(input pixel_t value, input int edge_num);
    longint acc;
    plane_mem[m_chan][m_pos] = value;
    if (m_chan == chan_t'(channels - 1)) begin
      acc = 0;
      for (int ch = 0; ch < channels; ch++) begin
        acc += longint'(plane_mem[chan_t'(ch)][m_pos]);
      end
      exp_sum_q.push_back(sum_t'(acc));
      exp_edge_q.push_back(edge_num);
      sums_expected++;
    end
    if (m_pos == pos_t'(plane_size - 1)) begin
      m_pos = '0;
      if (m_chan == chan_t'(channels - 1)) begin
        m_chan = '0;
        full_groups++;
      end else begin
        m_chan = m_chan + 1'b1;
      end
    end else begin
      m_pos = m_pos + 1'b1;
    end
  endtask

  task automatic model_restart();
    m_pos  = '0;
    m_chan = '0;
    exp_sum_q.delete();
    exp_edge_q.delete();
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  function automatic pixel_t next_pixel(input int mode);
    if (mode == mode_max) begin
      return pix_max;
    end else if (mode == mode_min) begin
      return pix_min;
    end
    return pixel_t'($urandom);
  endfunction

  // Idle cycles carry junk on pixel_in
  task automatic drive_cycle(input logic valid, input pixel_t value);
    @(posedge clk);
    #2;
    pixel_valid = valid;
    pixel_in    = valid ? value : pixel_t'($urandom);
    // Latency counts from the edge that launches the pixel
    if (valid) begin
      model_accept(value, cycle_count);
    end
  endtask

  task automatic send_pixels(input int count, input int mode, input int gap_pct);
    int gaps;
    for (int n = 0; n < count; n++) begin
      gaps = 0;
      while (gaps < 4 && ($urandom % 100) < gap_pct) begin
        drive_cycle(1'b0, '0);
        gaps++;
      end
      drive_cycle(1'b1, next_pixel(mode));
    end
  endtask

  task automatic send_group(input int mode, input int gap_pct);
    send_pixels(channels * plane_size, mode, gap_pct);
  endtask

  task automatic apply_reset();
    reset       = 1'b1;
    pixel_valid = 1'b0;
    repeat (8) begin
      @(posedge clk);
      #2;
    end
    reset = 1'b0;
  endtask

  task automatic drain(input string what);
    int waited;
    waited = 0;
    while (exp_sum_q.size() != 0 && waited < drain_limit) begin
      drive_cycle(1'b0, '0);
      waited++;
    end
    if (exp_sum_q.size() != 0) begin
      protocol_errors++;
      $display("Timeout after %s: %0d expected sums never arrived", what, exp_sum_q.size());
      exp_sum_q.delete();
      exp_edge_q.delete();
    end
    // Quiet stretch to catch stray strobes
    repeat (2 * latency) drive_cycle(1'b0, '0);
  endtask

  ////////////////////
  // Output monitor
  ////////////////////

  always @(negedge clk) begin : monitor_b
    sum_t exp_sum;
    int   exp_edge;
    if (!reset && sum_valid === 1'b1) begin
      sums_received++;
      if (exp_sum_q.size() == 0) begin
        protocol_errors++;
        $display("Unexpected sum_valid at cycle %0d, no last-channel pixel pending",
                 cycle_count);
      end else begin
        exp_sum  = exp_sum_q.pop_front();
        exp_edge = exp_edge_q.pop_front();
        compare_sum(exp_sum, sum_out);
        compare_latency(latency, cycle_count - exp_edge);
      end
    end
  end

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    void'($urandom(32'hc520_bca1));
    clk             = 1'b0;
    reset           = 1'b1;
    pixel_valid     = 1'b0;
    pixel_in        = '0;
    cycle_count     = 0;
    mismatch_errors = 0;
    latency_errors  = 0;
    protocol_errors = 0;
    sums_expected   = 0;
    sums_received   = 0;
    full_groups     = 0;
    model_restart();

    apply_reset();

    // Back-to-back full groups
    repeat (4) send_group(mode_random, 0);
    drain("back-to-back groups");

    // Valid gaps inside and between planes
    repeat (4) send_group(mode_random, 30);
    drain("groups with gaps");

    // Signed limits of the sum
    send_group(mode_max, 0);
    send_group(mode_min, 20);
    drain("extreme value groups");

    // Reset partway through channel 2, then one clean group
    send_pixels(2 * plane_size + plane_size / 2, mode_random, 10);
    apply_reset();
    model_restart();
    send_group(mode_random, 10);
    drain("group after mid-group reset");

    if (sums_received != full_groups * plane_size) begin
      protocol_errors++;
      $display("Received %0d sums but %0d full groups should give %0d",
               sums_received, full_groups, full_groups * plane_size);
    end
    if (sums_received != sums_expected) begin
      protocol_errors++;
      $display("Model queued %0d sums but DUT produced %0d", sums_expected, sums_received);
    end

    $display("Errors: mismatch %0d, latency %0d, protocol %0d",
             mismatch_errors, latency_errors, protocol_errors);
    if (mismatch_errors + latency_errors + protocol_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+include
design/channel_sum_pkg.sv
design/plane_delay.sv
design/channel_window.sv
design/adder_tree.sv
design/channel_sum_top.sv
tb/channel_sum_sva.sv
tb/channel_sum_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the channel sum testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f project.f --top-module channel_sum_tb \
  -Mdir obj_dir -o channel_sum_sim > build.log 2>&1 \
  && ./obj_dir/channel_sum_sim > sim.log 2>&1 \
  || { echo "Build or simulation did not complete"; cat build.log sim.log 2>/dev/null; exit 1; }

grep -qx "=== PASS ===" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; cat sim.log; exit 1; }
